/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_exe_top
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* all.f */
hdl/exe_pkg.sv
hdl/alu.sv
hdl/div_unit.sv
hdl/store_align.sv
hdl/exe_stage.sv
hdl/data_sram.sv
hdl/exe_top.sv
test/tb_exe_top.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
    import exe_pkg::*;
(
    input  alu_op_e     alu_op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    input  logic        ovf_check,
    output logic [31:0] result,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src2 << src1[4:0];   // shift amount from src1
            ALU_SRL:  result = src2 >> src1[4:0];
            ALU_SRA:  result = $signed(src2) >>> src1[4:0];
            ALU_LUI:  result = {src2[15:0], 16'b0};
            default:  result = 32'b0;               // div/divu come from the divider
        endcase
    end

    // signed overflow, only for the trapping forms
    assign overflow = ovf_check & (
        ((alu_op == ALU_ADD) & (src1[31] == src2[31]) & (sum[31] != src1[31])) |
        ((alu_op == ALU_SUB) & (src1[31] != src2[31]) & (diff[31] != src1[31])));

    always_comb begin
        if (!$isunknown({alu_op, src1, src2, ovf_check})) begin
            a_no_x: assert final (!$isunknown({result, overflow}))
                else $error("alu result unknown for op %s", alu_op.name());
        end
    end

endmodule

/* hdl/data_sram.sv */
`timescale 1ns/1ps

module data_sram
    import exe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  dreq_t       req,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   mem [DMEM_WORDS];
    logic [31:0]   byte_addr;
    logic [AW-1:0] word;
    logic          accept;

    assign byte_addr = {req.tag, req.index, req.offset};
    assign word      = byte_addr[AW+1:2];   // upper bits wrap
    assign addr_ok   = 1'b1;                // never busy
    assign accept    = req_valid & addr_ok;

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = 32'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[word];
            for (int b = 0; b < 4; b++) begin
                if (req.wr && req.wstrb[b])
                    mem[word][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            data_ok <= 1'b0;
        else
            data_ok <= accept;
    end

endmodule

/* hdl/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        flush,
    input  logic        is_signed,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder,
    output logic        done
);

    logic        busy;
    logic [4:0]  cnt;
    logic [31:0] quo_r;         // dividend shifts out, quotient shifts in
    logic [31:0] rem_r;
    logic [31:0] dsr_r;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] abs_a;
    logic [31:0] abs_b;
    logic [32:0] shifted;
    logic [32:0] trial;

    assign abs_a   = (is_signed && dividend[31]) ? -dividend : dividend;
    assign abs_b   = (is_signed && divisor[31]) ? -divisor : divisor;
    assign shifted = {rem_r, quo_r[31]};
    assign trial   = shifted - {1'b0, dsr_r};   // msb set means no subtract

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                cnt   <= 5'd0;
                quo_r <= abs_a;
                rem_r <= 32'b0;
                dsr_r <= abs_b;
                // divide by zero keeps the all-ones quotient
                neg_q <= is_signed & (dividend[31] ^ divisor[31]) & (|divisor);
                neg_r <= is_signed & dividend[31];
            end else if (busy) begin
                rem_r <= trial[32] ? shifted[31:0] : trial[31:0];
                quo_r <= {quo_r[30:0], ~trial[32]};
                cnt   <= cnt + 5'd1;
                if (cnt == 5'd31) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign quotient  = neg_q ? -quo_r : quo_r;
    assign remainder = neg_r ? -rem_r : rem_r;

    a_no_restart: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("divider started while busy");

    a_latency: assert property (@(posedge clk) disable iff (reset || flush)
        start |-> ##33 done)
        else $error("divider done not 33 cycles after start");

endmodule

/* hdl/exe_pkg.sv */
package exe_pkg;

    // alu and divider operations
    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI, ALU_DIV, ALU_DIVU
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
        MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR
    } mem_op_e;

    // cp0 cause codes, the rest arrive from decode
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        SRC2_RT, SRC2_ZIMM, SRC2_SIMM, SRC2_EIGHT
    } src2_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        src2_sel_e   src2_sel;
        logic        gr_we;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        inst_eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        bd;           // in a branch delay slot
        logic        ds_ex;
        exc_code_e   ds_exc_code;
        logic        ovf_check;    // add, addi, sub
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_e     mem_op;
        logic        res_from_mem;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        inst_eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        bd;
        logic        ex;
        exc_code_e   exc_code;
    } es_to_ms_t;

    // tag/index/offset concatenate to the byte address
    typedef struct packed {
        logic        wr;
        logic [19:0] tag;
        logic [7:0]  index;
        logic [3:0]  offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } dreq_t;

endpackage

/* hdl/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        ds_to_es_valid,
    input  ds_to_es_t   ds_to_es_bus,
    output logic        es_allowin,
    input  logic        ms_allowin,
    output logic        es_to_ms_valid,
    output es_to_ms_t   es_to_ms_bus,
    input  logic        ms_ex,
    input  logic        ws_ex,
    input  logic        ms_eret,
    input  logic        ws_eret,
    output logic [4:0]  fwd_dest,
    output logic [31:0] fwd_result,
    output logic        fwd_load,
    output logic        fwd_mfc0,
    output logic        data_valid,
    output dreq_t       data_req,
    input  logic        data_addr_ok,
    input  logic        data_data_ok
);

    ds_to_es_t   es;
    logic        es_valid;
    logic        es_ready_go;
    logic        issued;       // request sent or divider started
    logic        done_hold;    // response seen, waiting on ms_allowin
    logic        leave;
    logic        is_load;
    logic        is_store;
    logic        is_div;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic        overflow;
    logic [31:0] quotient;
    logic        div_start;
    logic        div_done;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        ades;
    logic        adel;
    logic        es_ex;
    exc_code_e   es_exc_code;
    logic        mem_block;
    logic        data_resp;
    logic [31:0] es_result;

    assign is_load  = es.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign is_store = es.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
    assign is_div   = es.alu_op inside {ALU_DIV, ALU_DIVU};
    assign leave    = es_to_ms_valid & ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin)
            es <= ds_to_es_bus;
    end

    assign src1 = es.src1_is_sa ? {27'b0, es.imm[10:6]} :
                  es.src1_is_pc ? es.pc : es.rs_value;

    always_comb begin
        case (es.src2_sel)
            SRC2_ZIMM:  src2 = {16'b0, es.imm};
            SRC2_SIMM:  src2 = {{16{es.imm[15]}}, es.imm};
            SRC2_EIGHT: src2 = 32'd8;          // link address pc+8
            default:    src2 = es.rt_value;
        endcase
    end

    alu u_alu (
        .alu_op    (es.alu_op),
        .src1      (src1),
        .src2      (src2),
        .ovf_check (es.ovf_check),
        .result    (alu_result),
        .overflow  (overflow)
    );

    assign div_start = es_valid & is_div & ~issued & ~flush;

    div_unit u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .flush     (flush),
        .is_signed (es.alu_op == ALU_DIV),
        .dividend  (es.rs_value),
        .divisor   (es.rt_value),
        .quotient  (quotient),
        .remainder (),
        .done      (div_done)
    );

    store_align u_align (
        .mem_op   (es.mem_op),
        .addr_low (alu_result[1:0]),
        .rt_value (es.rt_value),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .ades     (ades),
        .adel     (adel)
    );

    assign es_result   = es.inst_mtc0 ? es.rt_value : is_div ? quotient : alu_result;
    assign es_ex       = overflow | ades | adel | es.ds_ex;
    assign es_exc_code = overflow ? EXC_OV : ades ? EXC_ADES :
                         adel ? EXC_ADEL : es.ds_exc_code;

    // no memory access under a pending exception or eret
    assign mem_block  = es_ex | ms_ex | ws_ex | ms_eret | ws_eret;
    assign data_valid = es_valid & (is_load | is_store) & ~issued & ~mem_block
                        & ms_allowin & ~flush;
    assign data_resp  = data_data_ok & issued & is_load;

    always_comb begin
        data_req.wr = is_store;
        {data_req.tag, data_req.index, data_req.offset} = alu_result;
        data_req.wstrb = wstrb;
        data_req.wdata = wdata;
    end

    always_ff @(posedge clk) begin
        if (reset || flush || leave) begin
            issued    <= 1'b0;
            done_hold <= 1'b0;
        end else begin
            if ((data_valid && data_addr_ok) || div_start)
                issued <= 1'b1;
            // killed load also counts as finished
            if (data_resp || div_done || (es_valid && is_load && mem_block && !issued))
                done_hold <= 1'b1;
        end
    end

    always_comb begin
        if (is_load)
            es_ready_go = data_resp | done_hold | (mem_block & ~issued);
        else if (is_div)
            es_ready_go = div_done | done_hold;
        else if (is_store)
            es_ready_go = data_addr_ok | mem_block;
        else
            es_ready_go = 1'b1;
    end

    assign es_allowin     = ~es_valid | (es_ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid & es_ready_go;

    always_comb begin
        es_to_ms_bus.pc           = es.pc;
        es_to_ms_bus.result       = es_result;
        es_to_ms_bus.rt_value     = es.rt_value;
        es_to_ms_bus.dest         = es.dest;
        es_to_ms_bus.gr_we        = es.gr_we & ~es_ex;    // faulting op writes nothing
        es_to_ms_bus.mem_op       = es.mem_op;
        es_to_ms_bus.res_from_mem = is_load;
        es_to_ms_bus.inst_mfc0    = es.inst_mfc0;
        es_to_ms_bus.inst_mtc0    = es.inst_mtc0;
        es_to_ms_bus.inst_eret    = es.inst_eret;
        es_to_ms_bus.cp0_rd       = es.cp0_rd;
        es_to_ms_bus.cp0_sel      = es.cp0_sel;
        es_to_ms_bus.bd           = es.bd;
        es_to_ms_bus.ex           = es_ex;
        es_to_ms_bus.exc_code     = es_exc_code;
    end

    assign fwd_dest   = es_valid ? es.dest : 5'd0;
    assign fwd_result = es_result;
    assign fwd_load   = es_valid & is_load;
    assign fwd_mfc0   = es_valid & es.inst_mfc0;

    // a finished instruction stays offered until memory takes it
    a_hold_valid: assert property (@(posedge clk) disable iff (reset || flush)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && es_valid)
        else $error("es_to_ms_valid dropped under back-pressure");

    a_one_req: assert property (@(posedge clk) disable iff (reset || flush)
        data_valid && data_addr_ok && !leave |=> !data_valid)
        else $error("second data request for one instruction");

endmodule

/* hdl/exe_top.sv */
`timescale 1ns/1ps

module exe_top
    import exe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        ds_to_es_valid,
    input  ds_to_es_t   ds_to_es_bus,
    output logic        es_allowin,
    input  logic        ms_allowin,
    output logic        es_to_ms_valid,
    output es_to_ms_t   es_to_ms_bus,
    input  logic        ms_ex,
    input  logic        ws_ex,
    input  logic        ms_eret,
    input  logic        ws_eret,
    output logic [4:0]  fwd_dest,
    output logic [31:0] fwd_result,
    output logic        fwd_load,
    output logic        fwd_mfc0,
    output logic [31:0] load_rdata,
    output logic        load_rdata_valid
);

    logic        data_valid;
    dreq_t       data_req;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic [31:0] data_rdata;

    exe_stage u_exe (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_ex          (ms_ex),
        .ws_ex          (ws_ex),
        .ms_eret        (ms_eret),
        .ws_eret        (ws_eret),
        .fwd_dest       (fwd_dest),
        .fwd_result     (fwd_result),
        .fwd_load       (fwd_load),
        .fwd_mfc0       (fwd_mfc0),
        .data_valid     (data_valid),
        .data_req       (data_req),
        .data_addr_ok   (data_addr_ok),
        .data_data_ok   (data_data_ok)
    );

    data_sram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk       (clk),
        .reset     (reset),
        .req_valid (data_valid),
        .req       (data_req),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .rdata     (data_rdata)
    );

    // a load completes in its data_ok cycle
    assign load_rdata       = data_rdata;
    assign load_rdata_valid = data_data_ok & es_to_ms_valid & es_to_ms_bus.res_from_mem;

endmodule

/* hdl/store_align.sv */
`timescale 1ns/1ps

module store_align
    import exe_pkg::*;
(
    input  mem_op_e     mem_op,
    input  logic [1:0]  addr_low,
    input  logic [31:0] rt_value,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic        ades,
    output logic        adel
);

    always_comb begin
        wstrb = 4'b0000;      // loads write nothing
        wdata = rt_value;
        case (mem_op)
            MEM_SB: begin
                wstrb = 4'b0001 << addr_low;
                wdata = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            MEM_SW: wstrb = 4'b1111;
            // swl puts the upper bytes of rt at the low end of the word
            MEM_SWL: begin
                wstrb = 4'b1111 >> ~addr_low;
                wdata = rt_value >> {~addr_low, 3'b000};
            end
            MEM_SWR: begin
                wstrb = 4'b1111 << addr_low;
                wdata = rt_value << {addr_low, 3'b000};
            end
            default: ;
        endcase
    end

    assign ades = ((mem_op == MEM_SH) & addr_low[0]) |
                  ((mem_op == MEM_SW) & (|addr_low));
    assign adel = ((mem_op == MEM_LH || mem_op == MEM_LHU) & addr_low[0]) |
                  ((mem_op == MEM_LW) & (|addr_low));

endmodule

/* test/exe_testdata.hex */
// ctrl imm rs rt result exc load_word; ctrl: [7:0] alu_op [11:8] mem_op [15:12] src2_sel
// [16] sa [17] ovf_check [18] gr_we [27:20] dest [28] stall [29] flush [30] ms_ex [31] ws_eret
// exc: [4:0] expected code, [28] flushed so never leaves; a lone ffffffff ends the list
10340001 00000000 00000005 00000007 0000000c 00000000 00000000
00460000 00000000 7fffffff 00000001 80000000 0000000c 00000000
10562000 0000fffe 00000010 00000000 0000000e 00000000 00000000
10641007 00008000 12340000 00000000 12348000 00000000 00000000
1075000c 00000100 00000000 80000000 f8000000 00000000 00000000
1094100d 0000abcd 00000000 00000000 abcd0000 00000000 00000000
10b4000e 00000000 fffffff9 00000002 fffffffd 00000000 00000000
10c4000f 00000000 00001234 00000000 ffffffff 00000000 00000000
10d40001 00000000 00000001 00000002 00000003 00000000 00000000
10002801 00000000 00000040 11223344 00000040 00000000 00000000
10002601 00000001 00000040 000000aa 00000041 00000000 00000000
10002701 00000002 00000040 0000bbcc 00000042 00000000 00000000
11042501 00000000 00000040 00000000 00000040 00000000 bbccaa44
10002901 00000005 00000040 aabbccdd 00000045 00000000 00000000
10002a01 00000006 00000040 11223344 00000046 00000000 00000000
11142501 00000004 00000040 00000000 00000044 00000000 3344aabb
10002701 00000003 00000040 ffffffff 00000043 00000005 00000000
11242501 00000001 00000040 00000000 00000041 00000004 00000000
40002801 00000000 00000040 deadbeef 00000040 00000000 00000000
80002801 00000000 00000040 cafef00d 00000040 00000000 00000000
20002801 00000000 00000040 0badf00d 00000040 10000000 00000000
11542501 00000000 00000040 00000000 00000040 00000000 bbccaa44
ffffffff

/* test/tb_exe_top.sv */
`timescale 1ns/1ps

module tb_exe_top
    import exe_pkg::*;
();

    localparam int MAX_VEC = 64;
    localparam int WPV     = 7;     // words per vector line

    logic        clk;
    logic        reset;
    logic        flush;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es_bus;
    logic        es_allowin;
    logic        ms_allowin;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        ms_ex;
    logic        ws_ex;
    logic        ms_eret;
    logic        ws_eret;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_result;
    logic        fwd_load;
    logic        fwd_mfc0;
    logic [31:0] load_rdata;
    logic        load_rdata_valid;

    logic [31:0] vec_mem [MAX_VEC*WPV];
    integer      seed;
    int          nvec;
    int          cycles;
    int          limit;
    int          cur;
    bit          stall_on;
    bit          occupied;      // model of the stage valid bit
    bit          accepted;
    logic [4:0]  stage_dest;
    bit          stage_load;
    bit          stage_mfc0;
    int          exp_q[$];      // vectors inside the stage, oldest first

    exe_top #(.DMEM_WORDS(256)) dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] word(input int v, input int i);
        return vec_mem[v*WPV+i];
    endfunction

    function automatic logic [31:0] pc_of(input int v);
        return 32'h1000 + (32'(v) << 2);
    endfunction

    function automatic bit load_op(input logic [3:0] mem_op);
        return (mem_op >= 4'd1) && (mem_op <= 4'd5);
    endfunction

    // odd-numbered plain alu ops also carry the mfc0 flag
    function automatic bit mfc0_flag(input int v);
        logic [31:0] w0;
        w0 = word(v, 0);
        return (w0[11:8] == 4'd0) && !(alu_op_e'(w0[4:0]) inside {ALU_DIV, ALU_DIVU})
               && ((v % 2) == 1);
    endfunction

    task automatic stop_run(input string text);
        $display("%s", text);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] exp);
        stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, field, got, exp));
    endtask

    task automatic drive_bus(input int v);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = word(v, 0);
        w1 = word(v, 1);
        ds_to_es_bus            = '0;
        ds_to_es_bus.alu_op     = alu_op_e'(w0[4:0]);
        ds_to_es_bus.mem_op     = mem_op_e'(w0[11:8]);
        ds_to_es_bus.src2_sel   = src2_sel_e'(w0[13:12]);
        ds_to_es_bus.src1_is_sa = w0[16];
        ds_to_es_bus.ovf_check  = w0[17];
        ds_to_es_bus.gr_we      = w0[18];
        ds_to_es_bus.dest       = w0[24:20];
        ds_to_es_bus.imm        = w1[15:0];
        ds_to_es_bus.rs_value   = word(v, 2);
        ds_to_es_bus.rt_value   = word(v, 3);
        ds_to_es_bus.pc         = pc_of(v);
        ds_to_es_bus.inst_mfc0  = mfc0_flag(v);
        stall_on = w0[28];
        ms_ex    = w0[30];
        ws_eret  = w0[31];
    endtask

    task automatic check_leave(input int v);
        logic [31:0] w0;
        logic [31:0] w5;
        logic        exp_we;
        logic        exp_load;
        logic        exp_mfc0;
        w0 = word(v, 0);
        w5 = word(v, 5);
        exp_we   = w0[18] & (w5[4:0] == 5'd0);    // faulting op must not write
        exp_load = load_op(w0[11:8]);
        exp_mfc0 = mfc0_flag(v);
        assert (es_to_ms_bus.pc == pc_of(v)) else mismatch("pc", es_to_ms_bus.pc, pc_of(v));
        assert (es_to_ms_bus.result == word(v, 4))
            else mismatch("result", es_to_ms_bus.result, word(v, 4));
        assert (es_to_ms_bus.exc_code == w5[4:0])
            else mismatch("exc_code", 32'(es_to_ms_bus.exc_code), 32'(w5[4:0]));
        assert (es_to_ms_bus.ex == (w5[4:0] != 5'd0))
            else mismatch("ex", 32'(es_to_ms_bus.ex), 32'(w5[4:0] != 5'd0));
        assert (es_to_ms_bus.gr_we == exp_we)
            else mismatch("gr_we", 32'(es_to_ms_bus.gr_we), 32'(exp_we));
        assert (es_to_ms_bus.dest == w0[24:20])
            else mismatch("dest", 32'(es_to_ms_bus.dest), 32'(w0[24:20]));
        assert (es_to_ms_bus.res_from_mem == exp_load)
            else mismatch("res_from_mem", 32'(es_to_ms_bus.res_from_mem), 32'(exp_load));
        assert (es_to_ms_bus.rt_value == word(v, 3))
            else mismatch("rt_value", es_to_ms_bus.rt_value, word(v, 3));
        assert (es_to_ms_bus.mem_op == w0[11:8])
            else mismatch("mem_op", 32'(es_to_ms_bus.mem_op), 32'(w0[11:8]));
        assert (es_to_ms_bus.inst_mfc0 == exp_mfc0)
            else mismatch("inst_mfc0", 32'(es_to_ms_bus.inst_mfc0), 32'(exp_mfc0));
        assert (fwd_result == word(v, 4))
            else mismatch("fwd_result", fwd_result, word(v, 4));
    endtask

    // called just before the rising edge, inputs settled since the falling edge
    task automatic sample();
        logic [31:0] w0;
        logic [31:0] w5;
        cycles++;
        assert (cycles < limit) else stop_run("timeout: the stage stopped making progress");
        if (occupied) begin
            assert (fwd_dest == stage_dest)
                else mismatch("fwd_dest", 32'(fwd_dest), 32'(stage_dest));
            assert (fwd_load == stage_load)
                else mismatch("fwd_load", 32'(fwd_load), 32'(stage_load));
            assert (fwd_mfc0 == stage_mfc0)
                else mismatch("fwd_mfc0", 32'(fwd_mfc0), 32'(stage_mfc0));
        end else begin
            assert (fwd_dest == 5'd0) else mismatch("fwd_dest of empty stage", 32'(fwd_dest), 0);
            assert (!fwd_load && !fwd_mfc0)
                else mismatch("fwd flags of empty stage", 32'({fwd_load, fwd_mfc0}), 0);
        end
        if (load_rdata_valid) begin
            assert (exp_q.size() > 0)
                else stop_run("load data returned with no load in the stage");
            assert (load_rdata == word(exp_q[0], 6))
                else mismatch("load data", load_rdata, word(exp_q[0], 6));
        end
        // the memory side drops whatever it takes during a flush
        if (es_to_ms_valid && ms_allowin && !flush) begin
            assert (exp_q.size() > 0) else stop_run("an instruction left that was never expected");
            check_leave(exp_q.pop_front());
            occupied = 1'b0;
        end
        if (flush)
            occupied = 1'b0;
        accepted = ds_to_es_valid && es_allowin && !flush;
        if (accepted) begin
            w0 = word(cur, 0);
            w5 = word(cur, 5);
            occupied   = 1'b1;
            stage_dest = w0[24:20];
            stage_load = load_op(w0[11:8]);
            stage_mfc0 = mfc0_flag(cur);
            if (!w5[28])
                exp_q.push_back(cur);   // flushed ones never show up
        end
    endtask

    // v below zero leaves the decode side idle
    task automatic next_cycle(input int v, input bit fl);
        @(negedge clk);
        flush = fl;
        ds_to_es_valid = (v >= 0);
        if (v >= 0) begin
            cur = v;
            drive_bus(v);
        end
        // memory ready during a flush so only the flush keeps a store off the bus
        ms_allowin = (fl || !stall_on) ? 1'b1 : (($random(seed) & 3) != 0);
        #3;
        sample();
    endtask

    task automatic drain();
        while (occupied)
            next_cycle(-1, 1'b0);
    endtask

    initial begin
        logic [31:0] w0;
        seed           = 32'hb4b4c760;
        reset          = 1'b1;
        flush          = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        ms_allowin     = 1'b1;
        ms_ex          = 1'b0;
        ws_ex          = 1'b0;
        ms_eret        = 1'b0;
        ws_eret        = 1'b0;
        stall_on       = 1'b0;
        occupied       = 1'b0;
        accepted       = 1'b0;
        stage_dest     = 5'd0;
        stage_load     = 1'b0;
        stage_mfc0     = 1'b0;
        cycles         = 0;
        cur            = 0;
        $readmemh("test/exe_testdata.hex", vec_mem);
        nvec = 0;
        while (nvec < MAX_VEC && vec_mem[nvec*WPV] != 32'hffffffff)
            nvec++;
        limit = nvec * 60 + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int v = 0; v < nvec; v++) begin
            w0 = word(v, 0);
            if (|w0[31:29])
                drain();                // side conditions apply to this one alone
            do
                next_cycle(v, 1'b0);
            while (!accepted);
            if (w0[29])
                next_cycle(-1, 1'b1);   // kill the store in the stage
            if (|w0[31:29])
                drain();
        end
        drain();
        $display("Everything OK");
        $finish;
    end

endmodule
